// ==== design/swerv_dbg_pkg.sv ====
// Shared widths, DMI register map and sbcs field positions for the
// debug DCCM access path. Imported by every module of the design.

package swerv_dbg_pkg;

   // ******************************
   // Widths
   // ******************************
   localparam int DATA_W     = 32;   // Registers, APB data and DCCM words
   localparam int DMI_ADDR_W = 7;
   localparam int APB_ADDR_W = 9;    // paddr[8:2] carries the DMI address

   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [DMI_ADDR_W-1:0] dmi_addr_t;

   // ******************************
   // DMI register map
   // ******************************
   // Addresses as in the RISC-V debug specification
   localparam dmi_addr_t DMI_SBCS       = 7'h38;
   localparam dmi_addr_t DMI_SBADDRESS0 = 7'h39;
   localparam dmi_addr_t DMI_SBDATA0    = 7'h3c;

   // ******************************
   // sbcs fields
   // ******************************
   localparam int SBCS_ERROR_BIT      = 12;  // Sticky, write 1 to clear
   localparam int SBCS_READONDATA_BIT = 15;  // Read of sbdata0 starts next read
   localparam int SBCS_AUTOINC_BIT    = 16;  // Address steps by one word
   localparam int SBCS_READONADDR_BIT = 20;  // Write of sbaddress0 starts a read
   localparam int SBCS_BUSY_BIT       = 21;  // Read only

   // DCCM geometry
   // Words per bank; two banks interleaved on address bit 2
   localparam int DCCM_DEPTH_DEFAULT = 256;

endpackage

// ==== design/dmi_regs.sv ====
// DMI register block behind an APB slave port. Decodes sbcs, sbaddress0
// and sbdata0, holds the sbcs configuration and sbdata0, and raises the
// request pulses that drive the system-bus sequencer.

module dmi_regs (
   input  logic                                 clk,
   input  logic                                 rst_n,
   // APB slave
   input  logic                                 psel,
   input  logic                                 penable,
   input  logic                                 pwrite,
   input  logic [swerv_dbg_pkg::APB_ADDR_W-1:0] paddr,
   input  swerv_dbg_pkg::data_t                 pwdata,
   output swerv_dbg_pkg::data_t                 prdata,
   output logic                                 pready,
   output logic                                 pslverr,
   // Status from the sequencer
   input  swerv_dbg_pkg::data_t                 sb_addr,
   input  logic                                 busy,
   input  logic                                 err,
   input  logic                                 rd_valid,
   input  swerv_dbg_pkg::data_t                 rd_data,
   // Requests to the sequencer
   output logic                                 addr_wr,
   output swerv_dbg_pkg::data_t                 addr_wdata,
   output logic                                 rd_req,
   output logic                                 wr_req,
   output swerv_dbg_pkg::data_t                 wr_data,
   output logic                                 autoinc,
   output logic                                 err_clr
);
   import swerv_dbg_pkg::*;

   dmi_addr_t dmi_addr;
   logic      word_ok;
   logic      hit_sbcs;
   logic      hit_addr;
   logic      hit_data;
   logic      hit_any;
   logic      access;
   logic      done;
   logic      wr_done;
   logic      rd_done;
   logic      readonaddr;
   logic      readondata;
   data_t     sbcs_rd;
   data_t     sbdata0;

   // ******************************
   // Address decode
   // ******************************
   assign dmi_addr = paddr[APB_ADDR_W-1:2];
   assign word_ok  = (paddr[1:0] == 2'b00);   // Byte offsets are not mapped

   assign hit_sbcs = word_ok && (dmi_addr == DMI_SBCS);
   assign hit_addr = word_ok && (dmi_addr == DMI_SBADDRESS0);
   assign hit_data = word_ok && (dmi_addr == DMI_SBDATA0);
   assign hit_any  = hit_sbcs | hit_addr | hit_data;

   // ******************************
   // APB handshake
   // ******************************
   // sbaddress0 and sbdata0 stall while a bus access is in flight
   assign pready  = ~(hit_addr | hit_data) | ~busy;
   assign access  = psel & penable;
   assign done    = access & pready;             // Completing cycle
   assign pslverr = access & ~hit_any;

   assign wr_done = done & pwrite;
   assign rd_done = done & ~pwrite;

   // Request pulses, all in the completing cycle
   assign addr_wr    = wr_done & hit_addr;
   assign addr_wdata = pwdata;
   assign wr_req     = wr_done & hit_data;
   assign wr_data    = pwdata;
   assign rd_req     = (addr_wr & readonaddr) | (rd_done & hit_data & readondata);
   assign err_clr    = wr_done & hit_sbcs & pwdata[SBCS_ERROR_BIT];

   // sbcs as seen by the host
   always_comb begin
      sbcs_rd                      = '0;
      sbcs_rd[SBCS_ERROR_BIT]      = err;
      sbcs_rd[SBCS_READONDATA_BIT] = readondata;
      sbcs_rd[SBCS_AUTOINC_BIT]    = autoinc;
      sbcs_rd[SBCS_READONADDR_BIT] = readonaddr;
      sbcs_rd[SBCS_BUSY_BIT]       = busy;
   end

   always_comb begin
      prdata = '0;   // Unmapped reads return zero
      if (hit_sbcs) begin
         prdata = sbcs_rd;
      end else if (hit_addr) begin
         prdata = sb_addr;
      end else if (hit_data) begin
         prdata = sbdata0;   // Old value, a readondata fetch lands later
      end
   end

   // ******************************
   // Registers
   // ******************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         readonaddr <= 1'b0;
         readondata <= 1'b0;
         autoinc    <= 1'b0;
      end else if (wr_done && hit_sbcs) begin
         readonaddr <= pwdata[SBCS_READONADDR_BIT];
         readondata <= pwdata[SBCS_READONDATA_BIT];
         autoinc    <= pwdata[SBCS_AUTOINC_BIT];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sbdata0 <= '0;
      end else if (rd_valid) begin
         sbdata0 <= rd_data;       // Bus read return
      end else if (wr_req) begin
         sbdata0 <= pwdata;        // Host write also lands here
      end
   end

   // APB master never raises penable outside a selected transfer
   assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
      else $error("dmi_regs: penable without psel");

endmodule

// ==== design/sb_master.sv ====
// System-bus access sequencer for the debug path into the DCCM.
// Owns sbaddress0, checks range and alignment, steers each access to the
// lo or hi bank by address bit 2 and reports busy, error and read data.

module sb_master #(
   parameter int DCCM_DEPTH = swerv_dbg_pkg::DCCM_DEPTH_DEFAULT
) (
   input  logic                          clk,
   input  logic                          rst_n,
   // From the DMI register block
   input  logic                          addr_wr,
   input  swerv_dbg_pkg::data_t          addr_wdata,
   input  logic                          rd_req,
   input  logic                          wr_req,
   input  swerv_dbg_pkg::data_t          wr_data,
   input  logic                          autoinc,
   input  logic                          err_clr,
   // Back to the DMI register block
   output swerv_dbg_pkg::data_t          sb_addr,
   output logic                          busy,
   output logic                          err,
   output logic                          rd_valid,
   output swerv_dbg_pkg::data_t          rd_data,
   // DCCM banks
   output logic                          lo_en,
   output logic                          hi_en,
   output logic                          bank_wr_en,
   output logic [$clog2(DCCM_DEPTH)-1:0] bank_addr,
   output swerv_dbg_pkg::data_t          bank_wdata,
   input  swerv_dbg_pkg::data_t          lo_rdata,
   input  swerv_dbg_pkg::data_t          hi_rdata
);
   import swerv_dbg_pkg::*;

   localparam int    IDX_W      = $clog2(DCCM_DEPTH);
   localparam data_t ADDR_LIMIT = data_t'(8 * DCCM_DEPTH);   // Two banks of words

   logic  req;
   data_t req_addr;
   logic  bad_addr;
   logic  go;
   logic  rd_hi;

   // ******************************
   // Request check
   // ******************************
   // A readonaddr fetch uses the address written in the same cycle
   assign req      = rd_req | wr_req;
   assign req_addr = addr_wr ? addr_wdata : sb_addr;
   assign bad_addr = (req_addr[1:0] != 2'b00) || (req_addr >= ADDR_LIMIT);
   assign go       = req & ~bad_addr;

   // Enable cycle, plus the return cycle for reads
   assign busy    = lo_en | hi_en | rd_valid;
   assign rd_data = rd_hi ? hi_rdata : lo_rdata;

   // ******************************
   // Sequencer state
   // ******************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sb_addr    <= '0;
         lo_en      <= 1'b0;
         hi_en      <= 1'b0;
         bank_wr_en <= 1'b0;
         rd_valid   <= 1'b0;
         rd_hi      <= 1'b0;
         err        <= 1'b0;
      end else begin
         if (go && autoinc) begin
            sb_addr <= req_addr + data_t'(4);   // Step past the word just issued
         end else if (addr_wr) begin
            sb_addr <= addr_wdata;
         end

         lo_en      <= go & ~req_addr[2];
         hi_en      <= go & req_addr[2];
         bank_wr_en <= go & wr_req;

         // Bank output is valid the cycle after a read enable
         rd_valid <= (lo_en | hi_en) & ~bank_wr_en;
         rd_hi    <= hi_en;

         err <= (err & ~err_clr) | (req & bad_addr);   // Sticky until cleared
      end
   end

   // Word index and write data
   always_ff @(posedge clk) begin
      if (go) begin
         bank_addr  <= req_addr[IDX_W+2:3];
         bank_wdata <= wr_data;
      end
   end

   // ******************************
   // Checks
   // ******************************
   // Register block must hold requests back while an access is in flight
   assert property (@(posedge clk) disable iff (!rst_n) (rd_req || wr_req) |-> !busy)
      else $error("sb_master: request issued while busy");

   assert property (@(posedge clk) disable iff (!rst_n) !(lo_en && hi_en))
      else $error("sb_master: both DCCM banks enabled");

endmodule

// ==== design/dccm_bank.sv ====
// One single-port DCCM bank. A write stores the word in the enable cycle;
// a read presents the word on rdata in the following cycle.

module dccm_bank #(
   parameter int DCCM_DEPTH = swerv_dbg_pkg::DCCM_DEPTH_DEFAULT
) (
   input  logic                          clk,
   input  logic                          en,
   input  logic                          wr_en,
   input  logic [$clog2(DCCM_DEPTH)-1:0] addr,
   input  swerv_dbg_pkg::data_t          wdata,
   output swerv_dbg_pkg::data_t          rdata
);
   import swerv_dbg_pkg::*;

   data_t mem [DCCM_DEPTH];

   // ******************************
   // Storage
   // ******************************
   always_ff @(posedge clk) begin
      if (en) begin
         if (wr_en) begin
            mem[addr] <= wdata;
         end else begin
            rdata <= mem[addr];   // Registered read, holds until next read
         end
      end
   end

   // Sequencer must hand over a known in-range word index
   assert property (@(posedge clk) en |-> (!$isunknown(addr) && (addr < DCCM_DEPTH)))
      else $error("dccm_bank: enable with bad word index");

endmodule

// ==== design/swerv_dbg_wrapper.sv ====
// Top level of the debug DCCM path. An APB master reaches the DMI
// system-bus registers, which drive the sequencer and the two DCCM banks.
// DCCM_DEPTH sets the words per bank.

module swerv_dbg_wrapper #(
   parameter int DCCM_DEPTH = swerv_dbg_pkg::DCCM_DEPTH_DEFAULT
) (
   input  logic                                 clk,
   input  logic                                 rst_n,
   // APB slave
   input  logic                                 psel,
   input  logic                                 penable,
   input  logic                                 pwrite,
   input  logic [swerv_dbg_pkg::APB_ADDR_W-1:0] paddr,
   input  swerv_dbg_pkg::data_t                 pwdata,
   output swerv_dbg_pkg::data_t                 prdata,
   output logic                                 pready,
   output logic                                 pslverr
);
   import swerv_dbg_pkg::*;

   localparam int BANK_AW = $clog2(DCCM_DEPTH);

   // Register block to sequencer
   logic  addr_wr;
   data_t addr_wdata;
   logic  rd_req;
   logic  wr_req;
   data_t wr_data;
   logic  autoinc;
   logic  err_clr;
   data_t sb_addr;
   logic  busy;
   logic  err;
   logic  rd_valid;
   data_t rd_data;

   // Sequencer to DCCM banks
   logic               lo_en;
   logic               hi_en;
   logic               bank_wr_en;
   logic [BANK_AW-1:0] bank_addr;
   data_t              bank_wdata;
   data_t              lo_rdata;
   data_t              hi_rdata;

   // ******************************
   // Instances
   // ******************************
   dmi_regs dmi_regs_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .sb_addr    (sb_addr),
      .busy       (busy),
      .err        (err),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .addr_wr    (addr_wr),
      .addr_wdata (addr_wdata),
      .rd_req     (rd_req),
      .wr_req     (wr_req),
      .wr_data    (wr_data),
      .autoinc    (autoinc),
      .err_clr    (err_clr)
   );

   sb_master #(.DCCM_DEPTH(DCCM_DEPTH)) sb_master_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .addr_wr    (addr_wr),
      .addr_wdata (addr_wdata),
      .rd_req     (rd_req),
      .wr_req     (wr_req),
      .wr_data    (wr_data),
      .autoinc    (autoinc),
      .err_clr    (err_clr),
      .sb_addr    (sb_addr),
      .busy       (busy),
      .err        (err),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .lo_en      (lo_en),
      .hi_en      (hi_en),
      .bank_wr_en (bank_wr_en),
      .bank_addr  (bank_addr),
      .bank_wdata (bank_wdata),
      .lo_rdata   (lo_rdata),
      .hi_rdata   (hi_rdata)
   );

   // Address bit 2 clear
   dccm_bank #(.DCCM_DEPTH(DCCM_DEPTH)) dccm_lo (
      .clk   (clk),
      .en    (lo_en),
      .wr_en (bank_wr_en),
      .addr  (bank_addr),
      .wdata (bank_wdata),
      .rdata (lo_rdata)
   );

   // Address bit 2 set
   dccm_bank #(.DCCM_DEPTH(DCCM_DEPTH)) dccm_hi (
      .clk   (clk),
      .en    (hi_en),
      .wr_en (bank_wr_en),
      .addr  (bank_addr),
      .wdata (bank_wdata),
      .rdata (hi_rdata)
   );

endmodule

// ==== dv/tb_tests.svh ====
// Directed tests for the debug DCCM path, included into the testbench
// module body. Each task drives APB accesses and checks the responses.

`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

   localparam data_t BURST_BASE = 32'h200;
   localparam int    BURST_LEN  = 8;
   localparam data_t OOR_ADDR   = data_t'(8 * DEPTH);   // First byte past the hi bank

   // Registers come out of reset cleared
   task automatic reset_values();
      data_t rd;
      apb_read(PA_SBCS, rd);
      compare_word("reset_values", "sbcs", '0, rd);
      compare_word("reset_values", "pslverr", '0, data_t'(last_slverr));
      apb_read(PA_SBADDR, rd);
      compare_word("reset_values", "sbaddress0", '0, rd);
      apb_read(PA_SBDATA, rd);
      compare_word("reset_values", "sbdata0", '0, rd);
   endtask

   // One word in each bank, written then read back through readonaddr
   task automatic single_access();
      data_t addrs [2] = '{32'h40, 32'h1a4};   // Lo bank, hi bank
      data_t word;
      data_t rd;
      apb_write(PA_SBCS, '0);
      foreach (addrs[i]) begin
         apb_write(PA_SBADDR, addrs[i]);
         rand_word(word);
         apb_write(PA_SBDATA, word);
         mem_model[addrs[i]] = word;
      end
      apb_write(PA_SBCS, SBCS_RONA);
      foreach (addrs[i]) begin
         apb_write(PA_SBADDR, addrs[i]);
         apb_read(PA_SBDATA, rd);
         compare_word("single_access", $sformatf("word at %h", addrs[i]),
                      mem_model[addrs[i]], rd);
      end
   endtask

   // ******************************
   // Burst with auto-increment
   // ******************************
   task automatic burst_autoinc();
      data_t word;
      data_t rd;
      apb_write(PA_SBCS, SBCS_AUTO);
      apb_write(PA_SBADDR, BURST_BASE);
      for (int k = 0; k < BURST_LEN; k++) begin
         rand_word(word);
         apb_write(PA_SBDATA, word);
         mem_model[BURST_BASE + data_t'(4 * k)] = word;
         apb_read(PA_SBADDR, rd);
         compare_word("burst_autoinc", "sbaddress0 after write",
                      BURST_BASE + data_t'(4 * (k + 1)), rd);
      end
      apb_write(PA_SBCS, SBCS_RONA | SBCS_ROND | SBCS_AUTO);
      apb_write(PA_SBADDR, BURST_BASE);   // Prefetches word 0
      for (int k = 0; k < BURST_LEN; k++) begin
         apb_read(PA_SBDATA, rd);   // Returns word k, fetches word k+1
         compare_word("burst_autoinc", $sformatf("burst word %0d", k),
                      mem_model[BURST_BASE + data_t'(4 * k)], rd);
         apb_read(PA_SBADDR, rd);
         compare_word("burst_autoinc", "sbaddress0 after read",
                      BURST_BASE + data_t'(4 * (k + 2)), rd);
      end
      apb_write(PA_SBCS, '0);
   endtask

   // Reads of sbdata0 right behind a bus access
   task automatic back_pressure();
      data_t word;
      data_t rd;
      apb_write(PA_SBCS, '0);
      apb_write(PA_SBADDR, 32'h10c);
      rand_word(word);
      apb_write(PA_SBDATA, word);
      mem_model[32'h10c] = word;
      apb_read(PA_SBDATA, rd);
      compare_word("back_pressure", "sbdata0 after bus write", word, rd);
      apb_write(PA_SBCS, SBCS_RONA);
      apb_write(PA_SBADDR, 32'h40);
      apb_read(PA_SBDATA, rd);   // Bus read still in flight
      compare_word("back_pressure", "word at 00000040", mem_model[32'h40], rd);
      require("back_pressure", last_waits > 0,
              "sbdata0 read did not wait for the bus read in flight");
      apb_write(PA_SBADDR, 32'h10c);
      apb_read(PA_SBDATA, rd);
      compare_word("back_pressure", "word at 0000010c", mem_model[32'h10c], rd);
   endtask

   // ******************************
   // Error cases
   // ******************************
   task automatic error_cases();
      data_t word;
      data_t rd;
      apb_write(PA_SBCS, '0);
      rand_word(word);
      apb_write(PA_SBADDR, 32'h0);
      apb_write(PA_SBDATA, word);
      mem_model[32'h0] = word;
      rand_word(word);
      apb_write(PA_SBADDR, 32'h100);
      apb_write(PA_SBDATA, word);
      mem_model[32'h100] = word;

      apb_write(PA_SBADDR, OOR_ADDR);   // Word index would alias address 0
      rand_word(word);
      apb_write(PA_SBDATA, word);
      apb_read(PA_SBCS, rd);
      compare_word("error_cases", "error bit, out of range", 1, data_t'(rd[SBCS_ERROR_BIT]));
      apb_write(PA_SBCS, SBCS_ERR);
      apb_read(PA_SBCS, rd);
      compare_word("error_cases", "sbcs after clear", '0, rd);

      apb_write(PA_SBADDR, 32'h102);    // Unaligned, near 0x100
      rand_word(word);
      apb_write(PA_SBDATA, word);
      apb_read(PA_SBCS, rd);
      compare_word("error_cases", "error bit, unaligned", 1, data_t'(rd[SBCS_ERROR_BIT]));
      apb_write(PA_SBCS, SBCS_ERR);
      apb_read(PA_SBCS, rd);
      compare_word("error_cases", "sbcs after clear", '0, rd);

      // Stored words must be untouched
      apb_write(PA_SBCS, SBCS_RONA);
      apb_write(PA_SBADDR, 32'h0);
      apb_read(PA_SBDATA, rd);
      compare_word("error_cases", "word at 00000000", mem_model[32'h0], rd);
      apb_write(PA_SBADDR, 32'h100);
      apb_read(PA_SBDATA, rd);
      compare_word("error_cases", "word at 00000100", mem_model[32'h100], rd);

      apb_read(9'h000, rd);
      compare_word("error_cases", "unmapped read data", '0, rd);
      compare_word("error_cases", "unmapped read pslverr", 1, data_t'(last_slverr));
      apb_write(9'h1fc, 32'hffff_ffff);
      compare_word("error_cases", "unmapped write pslverr", 1, data_t'(last_slverr));
      apb_read(PA_SBADDR, rd);
      compare_word("error_cases", "sbaddress0 after unmapped write", 32'h100, rd);
   endtask

`endif

// ==== dv/tb_top.sv ====
// Testbench for the debug DCCM path. Acts as the APB master of the
// wrapper, runs the included directed tests and prints one verdict.

module tb_top;
   import swerv_dbg_pkg::*;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   localparam int DRIVE_DELAY  = 1;    // Inputs change this long after posedge
   localparam int DEPTH        = DCCM_DEPTH_DEFAULT;
   localparam int ACCESS_COUNT = 82;   // APB accesses over all tests
   localparam int WATCHDOG_TIME = ACCESS_COUNT * 10 * CLK_PERIOD
                                + RESET_CYCLES * CLK_PERIOD;

   // APB byte addresses of the DMI registers
   localparam logic [APB_ADDR_W-1:0] PA_SBCS  = {DMI_SBCS, 2'b00};
   localparam logic [APB_ADDR_W-1:0] PA_SBADDR = {DMI_SBADDRESS0, 2'b00};
   localparam logic [APB_ADDR_W-1:0] PA_SBDATA = {DMI_SBDATA0, 2'b00};

   localparam data_t SBCS_ERR  = data_t'(1 << SBCS_ERROR_BIT);
   localparam data_t SBCS_ROND = data_t'(1 << SBCS_READONDATA_BIT);
   localparam data_t SBCS_AUTO = data_t'(1 << SBCS_AUTOINC_BIT);
   localparam data_t SBCS_RONA = data_t'(1 << SBCS_READONADDR_BIT);

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [APB_ADDR_W-1:0] paddr;
   data_t                 pwdata;
   data_t                 prdata;
   logic                  pready;
   logic                  pslverr;

   int          error_count = 0;
   int          check_count = 0;
   int          access_count = 0;
   int          last_waits;          // Stall cycles of the last access
   logic        last_slverr;
   logic [15:0] lfsr_state = 16'd55075;
   data_t       mem_model [data_t];  // Expected DCCM contents by byte address

   always #(CLK_PERIOD / 2) clk = ~clk;

   swerv_dbg_wrapper #(.DCCM_DEPTH(DEPTH)) swerv_dbg_wrapper_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   // ******************************
   // Helpers
   // ******************************
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_word(output data_t w);
      w = '0;
      for (int i = 0; i < DATA_W; i++) begin
         w          = {w[DATA_W-2:0], lfsr_state[15]};
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   task automatic compare_word(input string test, input string what,
                               input data_t expected, input data_t actual);
      check_count++;
      assert (actual === expected) else begin
         error_count++;
         $display("MISMATCH %s: %s expected %h, actual %h", test, what, expected, actual);
      end
   endtask

   task automatic require(input string test, input bit cond, input string what);
      check_count++;
      assert (cond) else begin
         error_count++;
         $display("ERROR %s: %s", test, what);
      end
   endtask

   // One APB transfer that starts and ends just after a rising edge
   task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                             input data_t wdata, output data_t rdata);
      logic got;
      got     = 1'b0;
      rdata   = '0;
      psel    = 1'b1;   // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #DRIVE_DELAY;
      penable    = 1'b1;
      last_waits = 0;
      while (!got) begin
         @(negedge clk);   // pready settled by mid cycle
         if (pready) begin
            got         = 1'b1;
            rdata       = prdata;
            last_slverr = pslverr;
         end else begin
            last_waits++;
         end
      end
      @(posedge clk);
      #DRIVE_DELAY;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      access_count++;
   endtask

   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input data_t wdata);
      data_t ignored;
      apb_access(1'b1, addr, wdata, ignored);
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output data_t rdata);
      apb_access(1'b0, addr, '0, rdata);
   endtask

`include "tb_tests.svh"

   // ******************************
   // Sequence and report
   // ******************************
   initial begin
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;

      reset_values();
      single_access();
      burst_autoinc();
      back_pressure();
      error_cases();

      $display("Checks run: %0d, errors: %0d, APB accesses: %0d",
               check_count, error_count, access_count);
      if (error_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("ERROR: watchdog expired after %0t, an APB access never completed", $time);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== verilog.f ====
design/swerv_dbg_pkg.sv
design/dmi_regs.sv
design/sb_master.sv
design/dccm_bank.sv
design/swerv_dbg_wrapper.sv
+incdir+dv
dv/tb_top.sv

// ==== Makefile ====
# Verilator build and run for the debug DCCM path testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard dv/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
